/* src/slam_consts.svh */
`ifndef SLAM_CONSTS_SVH
`define SLAM_CONSTS_SVH

// signed state word width
`define SLAM_DW        32

// landmark slot index and slot count
`define LM_IDX_W       4
`define LM_DEPTH       16

// host bram port
`define PLB_AW         10
// pose x, y, theta at base, base+1, base+2
`define PLB_POSE_BASE  0
// slot s at base+2s (x) and base+2s+1 (y)
`define PLB_LM_BASE    16

// words per write-back
`define POSE_WORDS     3
`define LM_WORDS       2
// counter wide enough for the longer burst
`define WB_CNT_W       2

`endif

/* src/slam_pkg.sv */
`default_nettype none

`include "slam_consts.svh"

package slam_pkg;

  // stage codes seen on the host handshake
  // codes 3..7 belong to stages this block does not run
  typedef enum logic [2:0] {
    STAGE_IDLE = 3'd0,
    STAGE_PRD  = 3'd1,
    STAGE_NEW  = 3'd2
  } stage_e;

  // robot pose, x in the top word
  typedef struct packed {
    logic signed [`SLAM_DW-1:0] x;
    logic signed [`SLAM_DW-1:0] y;
    logic signed [`SLAM_DW-1:0] theta;
  } pose_t;

endpackage

`default_nettype wire

/* src/seq_if.sv */
`timescale 1ns/1ns
`default_nettype none

// sequencing strobes between stage_ctrl and the datapath
interface seq_if;

  // capture pulses, high in the cycle done arrives
  logic cap_pose;
  logic cap_lm;
  // write-back kick and kind
  logic wb_start;
  logic wb_is_lm;
  // last word on the bram port
  logic wb_done;

  modport ctrl (
    output cap_pose, cap_lm, wb_start, wb_is_lm,
    input  wb_done
  );

  modport dp (
    input  cap_pose, cap_lm, wb_start, wb_is_lm,
    output wb_done
  );

endinterface

`default_nettype wire

/* src/stage_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

`include "slam_consts.svh"

module stage_ctrl import slam_pkg::*; (
  input  wire    clk,
  input  wire    sys_rst,
  // host stage handshake
  input  stage_e i_stage_val,
  output stage_e o_stage_rdy,
  // nonlinear unit exchange
  input  wire    i_done_predict,
  input  wire    i_done_newlm,
  output logic   o_init_predict,
  output logic   o_init_newlm,
  // strobes to the datapath
  seq_if.ctrl    seq
);

  typedef enum logic [2:0] {
    S_IDLE,
    S_START,
    S_WAIT,
    S_WB,
    S_DONE
  } state_e;

  state_e state;
  // accepted stage code, held until the stage finishes
  stage_e stage_q;
  logic   wb_start_q;
  logic   is_prd;
  logic   is_new;
  logic   cap_any;

  assign is_prd = (stage_q == STAGE_PRD);
  assign is_new = (stage_q == STAGE_NEW);

  // single init cycle right after the code is taken
  assign o_init_predict = (state == S_START) && is_prd;
  assign o_init_newlm   = (state == S_START) && is_new;

  // results are only valid while done is high, so capture straight off it
  assign seq.cap_pose = (state == S_WAIT) && is_prd && i_done_predict;
  assign seq.cap_lm   = (state == S_WAIT) && is_new && i_done_newlm;
  assign cap_any      = seq.cap_pose || seq.cap_lm;

  assign seq.wb_start = wb_start_q;
  assign seq.wb_is_lm = is_new;

  // echo the code for the single DONE cycle
  assign o_stage_rdy = (state == S_DONE) ? stage_q : STAGE_IDLE;

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      state      <= S_IDLE;
      stage_q    <= STAGE_IDLE;
      wb_start_q <= 1'b0;
    end else begin
      // kick write-back one cycle after the capture edge
      wb_start_q <= cap_any;
      case (state)
        S_IDLE: begin
          // other codes are left alone
          if (i_stage_val == STAGE_PRD || i_stage_val == STAGE_NEW) begin
            stage_q <= i_stage_val;
            state   <= S_START;
          end
        end
        S_START: begin
          state <= S_WAIT;
        end
        S_WAIT: begin
          // the unit may take any number of cycles
          if (cap_any) begin
            state <= S_WB;
          end
        end
        S_WB: begin
          if (seq.wb_done) begin
            state <= S_DONE;
          end
        end
        S_DONE: begin
          stage_q <= STAGE_IDLE;
          state   <= S_IDLE;
        end
        default: begin
          state <= S_IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* src/pose_update.sv */
`timescale 1ns/1ns
`default_nettype none

`include "slam_consts.svh"

module pose_update import slam_pkg::*; (
  input  wire                       clk,
  input  wire                       sys_rst,
  seq_if.dp                         seq,
  // predict increments from the nonlinear unit
  // result_1 is dtheta, result_2 is dx, result_3 is dy
  input  wire signed [`SLAM_DW-1:0] i_result_1,
  input  wire signed [`SLAM_DW-1:0] i_result_2,
  input  wire signed [`SLAM_DW-1:0] i_result_3,
  output pose_t                     o_pose
);

  pose_t pose_q;

  // robot starts at the origin
  // all three sums wrap at the word width
  always_ff @(posedge clk) begin
    if (sys_rst) begin
      pose_q <= '0;
    end else if (seq.cap_pose) begin
      pose_q.x     <= pose_q.x + i_result_2;
      pose_q.y     <= pose_q.y + i_result_3;
      pose_q.theta <= pose_q.theta + i_result_1;
    end
  end

  // pose goes to the host, the landmark store and the writer
  assign o_pose = pose_q;

endmodule

`default_nettype wire

/* src/landmark_store.sv */
`timescale 1ns/1ns
`default_nettype none

`include "slam_consts.svh"

module landmark_store import slam_pkg::*; (
  input  wire                        clk,
  input  wire                        sys_rst,
  seq_if.dp                          seq,
  // slot under work, also the read select
  input  wire        [`LM_IDX_W-1:0] i_l_k,
  input  pose_t                      i_pose,
  // offsets from the robot
  // result_3 along x and result_2 along y
  input  wire signed [`SLAM_DW-1:0]  i_result_2,
  input  wire signed [`SLAM_DW-1:0]  i_result_3,
  output logic signed [`SLAM_DW-1:0] o_lkx,
  output logic signed [`SLAM_DW-1:0] o_lky
);

  logic signed [`SLAM_DW-1:0] lm_x [`LM_DEPTH];
  logic signed [`SLAM_DW-1:0] lm_y [`LM_DEPTH];

  // empty map reads back as zero
  always_ff @(posedge clk) begin
    if (sys_rst) begin
      for (int i = 0; i < `LM_DEPTH; i++) begin
        lm_x[i] <= '0;
        lm_y[i] <= '0;
      end
    end else if (seq.cap_lm) begin
      // placed relative to the pose held before this stage
      lm_x[i_l_k] <= i_pose.x + i_result_3;
      lm_y[i_l_k] <= i_pose.y + i_result_2;
    end
  end

  // async read
  // the nonlinear unit and the writer both look at slot l_k
  assign o_lkx = lm_x[i_l_k];
  assign o_lky = lm_y[i_l_k];

endmodule

`default_nettype wire

/* src/plb_writer.sv */
`timescale 1ns/1ns
`default_nettype none

`include "slam_consts.svh"

module plb_writer import slam_pkg::*; (
  input  wire                        clk,
  input  wire                        sys_rst,
  seq_if.dp                          seq,
  input  wire        [`LM_IDX_W-1:0] i_l_k,
  input  pose_t                      i_pose,
  input  wire signed [`SLAM_DW-1:0]  i_lkx,
  input  wire signed [`SLAM_DW-1:0]  i_lky,
  // host bram, write only
  output logic                       o_plb_en,
  output logic                       o_plb_we,
  output logic       [`PLB_AW-1:0]   o_plb_addr,
  output logic signed [`SLAM_DW-1:0] o_plb_din
);

  logic                 busy;
  logic [`WB_CNT_W-1:0] word_idx;
  logic [`WB_CNT_W-1:0] last_idx;
  logic [`PLB_AW-1:0]   base_addr;
  logic                 last_word;

  // burst length by kind
  assign last_idx = seq.wb_is_lm ? `WB_CNT_W'(`LM_WORDS - 1)
                                 : `WB_CNT_W'(`POSE_WORDS - 1);

  // two words per landmark slot
  assign base_addr = seq.wb_is_lm ? `PLB_AW'(`PLB_LM_BASE + 2 * i_l_k)
                                  : `PLB_AW'(`PLB_POSE_BASE);

  assign last_word = busy && (word_idx == last_idx);

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      busy     <= 1'b0;
      word_idx <= '0;
    end else if (seq.wb_start) begin
      busy     <= 1'b1;
      word_idx <= '0;
    end else if (busy) begin
      if (last_word) begin
        busy     <= 1'b0;
        word_idx <= '0;
      end else begin
        word_idx <= word_idx + 1'b1;
      end
    end
  end

  // one write per busy cycle, no stalls from the bram
  assign o_plb_en   = busy;
  assign o_plb_we   = busy;
  assign o_plb_addr = base_addr + `PLB_AW'(word_idx);

  // pose order x, y, theta
  // landmark order x, y
  always_comb begin
    if (seq.wb_is_lm) begin
      o_plb_din = (word_idx == '0) ? i_lkx : i_lky;
    end else begin
      case (word_idx)
        `WB_CNT_W'(0): o_plb_din = i_pose.x;
        `WB_CNT_W'(1): o_plb_din = i_pose.y;
        default:       o_plb_din = i_pose.theta;
      endcase
    end
  end

  // flagged together with the last word
  assign seq.wb_done = last_word;

endmodule

`default_nettype wire

/* src/slam_accel_top.sv */
`timescale 1ns/1ns
`default_nettype none

`include "slam_consts.svh"

module slam_accel_top import slam_pkg::*; (
  input  wire                         clk,
  input  wire                         sys_rst,
  // host stage handshake
  input  wire         [2:0]           i_stage_val,
  output logic        [2:0]           o_stage_rdy,
  input  wire         [`LM_IDX_W-1:0] i_l_k,
  // nonlinear unit
  output logic                        o_init_predict,
  output logic                        o_init_newlm,
  input  wire                         i_done_predict,
  input  wire                         i_done_newlm,
  // result_0 feeds only the update stage, which is not here
  input  wire signed  [`SLAM_DW-1:0]  i_result_0,
  input  wire signed  [`SLAM_DW-1:0]  i_result_1,
  input  wire signed  [`SLAM_DW-1:0]  i_result_2,
  input  wire signed  [`SLAM_DW-1:0]  i_result_3,
  // state seen by the nonlinear unit
  output logic signed [`SLAM_DW-1:0]  o_xk,
  output logic signed [`SLAM_DW-1:0]  o_yk,
  output logic signed [`SLAM_DW-1:0]  o_xita,
  output logic signed [`SLAM_DW-1:0]  o_lkx,
  output logic signed [`SLAM_DW-1:0]  o_lky,
  // host bram
  output logic                        o_plb_en,
  output logic                        o_plb_we,
  output logic        [`PLB_AW-1:0]   o_plb_addr,
  output logic signed [`SLAM_DW-1:0]  o_plb_din
);

  seq_if u_seq ();

  pose_t  pose;
  stage_e stage_rdy;

  stage_ctrl u_stage_ctrl (
    .clk            (clk),
    .sys_rst        (sys_rst),
    .i_stage_val    (stage_e'(i_stage_val)),
    .o_stage_rdy    (stage_rdy),
    .i_done_predict (i_done_predict),
    .i_done_newlm   (i_done_newlm),
    .o_init_predict (o_init_predict),
    .o_init_newlm   (o_init_newlm),
    .seq            (u_seq.ctrl)
  );

  pose_update u_pose_update (
    .clk        (clk),
    .sys_rst    (sys_rst),
    .seq        (u_seq.dp),
    .i_result_1 (i_result_1),
    .i_result_2 (i_result_2),
    .i_result_3 (i_result_3),
    .o_pose     (pose)
  );

  landmark_store u_landmark_store (
    .clk        (clk),
    .sys_rst    (sys_rst),
    .seq        (u_seq.dp),
    .i_l_k      (i_l_k),
    .i_pose     (pose),
    .i_result_2 (i_result_2),
    .i_result_3 (i_result_3),
    .o_lkx      (o_lkx),
    .o_lky      (o_lky)
  );

  // writer reads the landmark slot back through the top outputs
  plb_writer u_plb_writer (
    .clk        (clk),
    .sys_rst    (sys_rst),
    .seq        (u_seq.dp),
    .i_l_k      (i_l_k),
    .i_pose     (pose),
    .i_lkx      (o_lkx),
    .i_lky      (o_lky),
    .o_plb_en   (o_plb_en),
    .o_plb_we   (o_plb_we),
    .o_plb_addr (o_plb_addr),
    .o_plb_din  (o_plb_din)
  );

  assign o_stage_rdy = stage_rdy;
  assign o_xk        = pose.x;
  assign o_yk        = pose.y;
  assign o_xita      = pose.theta;

endmodule

`default_nettype wire

/* bench/slam_accel_tb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "slam_consts.svh"

module slam_accel_tb import slam_pkg::*; ();

  localparam int SEED        = 17065;
  localparam int RDY_TIMEOUT = 60;
  localparam int MIX_STAGES  = 6;
  localparam int PRD_RUNS    = 20;

  logic                       clk;
  logic                       sys_rst;
  logic [2:0]                 stage_val;
  logic [`LM_IDX_W-1:0]       l_k;
  logic                       done_predict;
  logic                       done_newlm;
  logic signed [`SLAM_DW-1:0] result_0;
  logic signed [`SLAM_DW-1:0] result_1;
  logic signed [`SLAM_DW-1:0] result_2;
  logic signed [`SLAM_DW-1:0] result_3;

  logic [2:0]                 o_stage_rdy;
  logic                       o_init_predict;
  logic                       o_init_newlm;
  logic signed [`SLAM_DW-1:0] o_xk;
  logic signed [`SLAM_DW-1:0] o_yk;
  logic signed [`SLAM_DW-1:0] o_xita;
  logic signed [`SLAM_DW-1:0] o_lkx;
  logic signed [`SLAM_DW-1:0] o_lky;
  logic                       o_plb_en;
  logic                       o_plb_we;
  logic [`PLB_AW-1:0]         o_plb_addr;
  logic signed [`SLAM_DW-1:0] o_plb_din;

  // reference model state
  logic signed [`SLAM_DW-1:0] ref_x;
  logic signed [`SLAM_DW-1:0] ref_y;
  logic signed [`SLAM_DW-1:0] ref_th;
  logic signed [`SLAM_DW-1:0] ref_lx [`LM_DEPTH];
  logic signed [`SLAM_DW-1:0] ref_ly [`LM_DEPTH];
  // expected bram writes, in order
  logic [`PLB_AW-1:0]         exp_addr_q [$];
  logic signed [`SLAM_DW-1:0] exp_data_q [$];

  int err_cnt = 0;
  int pass_cnt = 0;
  int fail_cnt = 0;
  // pulse and write counters from the monitor
  int init_prd_cnt = 0;
  int init_new_cnt = 0;
  int rdy_cnt = 0;
  int wr_cnt = 0;
  int nl_delay;
  logic nl_is_lm;
  logic [`PLB_AW-1:0]         mon_addr;
  logic signed [`SLAM_DW-1:0] mon_data;

  slam_accel_top dut_i (
    .clk            (clk),
    .sys_rst        (sys_rst),
    .i_stage_val    (stage_val),
    .o_stage_rdy    (o_stage_rdy),
    .i_l_k          (l_k),
    .o_init_predict (o_init_predict),
    .o_init_newlm   (o_init_newlm),
    .i_done_predict (done_predict),
    .i_done_newlm   (done_newlm),
    .i_result_0     (result_0),
    .i_result_1     (result_1),
    .i_result_2     (result_2),
    .i_result_3     (result_3),
    .o_xk           (o_xk),
    .o_yk           (o_yk),
    .o_xita         (o_xita),
    .o_lkx          (o_lkx),
    .o_lky          (o_lky),
    .o_plb_en       (o_plb_en),
    .o_plb_we       (o_plb_we),
    .o_plb_addr     (o_plb_addr),
    .o_plb_din      (o_plb_din)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // folds one stage into the reference and queues the words it should write
  function automatic void ref_stage(input logic is_lm, input logic [`LM_IDX_W-1:0] slot,
                                    input logic signed [`SLAM_DW-1:0] r1,
                                    input logic signed [`SLAM_DW-1:0] r2,
                                    input logic signed [`SLAM_DW-1:0] r3);
    if (!is_lm) begin
      // dx in result_2, dy in result_3, dtheta in result_1
      ref_x  = ref_x + r2;
      ref_y  = ref_y + r3;
      ref_th = ref_th + r1;
      exp_addr_q.push_back(`PLB_AW'(`PLB_POSE_BASE));
      exp_addr_q.push_back(`PLB_AW'(`PLB_POSE_BASE + 1));
      exp_addr_q.push_back(`PLB_AW'(`PLB_POSE_BASE + 2));
      exp_data_q.push_back(ref_x);
      exp_data_q.push_back(ref_y);
      exp_data_q.push_back(ref_th);
    end else begin
      // landmark sits at the pose plus (result_3, result_2)
      ref_lx[slot] = ref_x + r3;
      ref_ly[slot] = ref_y + r2;
      exp_addr_q.push_back(`PLB_AW'(`PLB_LM_BASE + 2 * slot));
      exp_addr_q.push_back(`PLB_AW'(`PLB_LM_BASE + 2 * slot + 1));
      exp_data_q.push_back(ref_lx[slot]);
      exp_data_q.push_back(ref_ly[slot]);
    end
  endfunction

  // nonlinear unit model answering each init after 1 to 8 cycles
  always begin
    @(negedge clk);
    if (o_init_predict || o_init_newlm) begin
      nl_is_lm = o_init_newlm;
      nl_delay = 1 + int'($urandom % 8);
      repeat (nl_delay) @(posedge clk);
      #1;
      result_0     = $urandom;
      result_1     = $urandom;
      result_2     = $urandom;
      result_3     = $urandom;
      done_predict = !nl_is_lm;
      done_newlm   = nl_is_lm;
      ref_stage(nl_is_lm, l_k, result_1, result_2, result_3);
      // results only valid in the done cycle
      @(posedge clk);
      #1;
      done_predict = 1'b0;
      done_newlm   = 1'b0;
    end
  end

  // watches pulses and compares every bram write
  always @(negedge clk) begin
    if (o_init_predict) init_prd_cnt++;
    if (o_init_newlm) init_new_cnt++;
    if (o_stage_rdy != 3'd0) rdy_cnt++;
    if (o_plb_en) begin
      wr_cnt++;
      if (exp_addr_q.size() == 0) begin
        err_cnt++;
        $display("unexpected BRAM write to address %0d at %0t", o_plb_addr, $time);
      end else begin
        mon_addr = exp_addr_q.pop_front();
        mon_data = exp_data_q.pop_front();
        assert (o_plb_we && o_plb_addr == mon_addr && o_plb_din == mon_data) else begin
          err_cnt++;
          $display("** Error at %0t: write addr %0d data %0h, expected addr %0d data %0h",
                   $time, o_plb_addr, o_plb_din, mon_addr, mon_data);
        end
      end
    end
  end

  task automatic abort_run(input string why);
    $display("timeout while waiting for %s at %0t", why, $time);
    $display("=== FAIL ===");
    $finish;
  endtask

  task automatic finish_test(input string name, input int err_before);
    if (err_cnt == err_before) begin
      pass_cnt++;
      $display("%-28s ok", name);
    end else begin
      fail_cnt++;
      $display("%-28s FAILED with %0d errors", name, err_cnt - err_before);
    end
  endtask

  // runs one stage through the host handshake and checks its pulses
  task automatic run_stage(input logic [2:0] code, input logic [`LM_IDX_W-1:0] slot);
    int prd0;
    int new0;
    int rdy0;
    int wr0;
    int wr_rdy;
    int n;
    int words;
    prd0  = init_prd_cnt;
    new0  = init_new_cnt;
    rdy0  = rdy_cnt;
    wr0   = wr_cnt;
    n     = 0;
    words = (code == STAGE_PRD) ? `POSE_WORDS : `LM_WORDS;
    @(posedge clk);
    #1;
    stage_val = code;
    l_k       = slot;
    do begin
      @(negedge clk);
      n++;
    end while (o_stage_rdy != code && n < RDY_TIMEOUT);
    if (o_stage_rdy != code) abort_run("stage_rdy");
    // code back to idle once rdy is seen
    @(posedge clk);
    #1;
    stage_val = STAGE_IDLE;
    // all writes must already be in by now
    wr_rdy    = wr_cnt;
    repeat (2) @(negedge clk);
    assert (init_prd_cnt - prd0 == ((code == STAGE_PRD) ? 1 : 0) &&
            init_new_cnt - new0 == ((code == STAGE_NEW) ? 1 : 0)) else begin
      err_cnt++;
      $display("** Error at %0t: stage %0d gave %0d predict and %0d newlm inits",
               $time, code, init_prd_cnt - prd0, init_new_cnt - new0);
    end
    assert (rdy_cnt - rdy0 == 1) else begin
      err_cnt++;
      $display("** Error at %0t: stage_rdy high for %0d cycles", $time, rdy_cnt - rdy0);
    end
    assert (wr_cnt - wr0 == words && wr_rdy == wr_cnt && exp_addr_q.size() == 0) else begin
      err_cnt++;
      $display("** Error at %0t: %0d writes, %0d after stage_rdy, expected %0d before it",
               $time, wr_cnt - wr0, wr_cnt - wr_rdy, words);
    end
  endtask

  task automatic check_pose();
    assert (o_xk == ref_x && o_yk == ref_y && o_xita == ref_th) else begin
      err_cnt++;
      $display("** Error at %0t: pose %0h %0h %0h, expected %0h %0h %0h",
               $time, o_xk, o_yk, o_xita, ref_x, ref_y, ref_th);
    end
  endtask

  initial begin
    int err0;
    int prd0;
    int new0;
    int rdy0;
    int wr0;
    void'($urandom(SEED));
    sys_rst      = 1'b1;
    stage_val    = STAGE_IDLE;
    l_k          = '0;
    done_predict = 1'b0;
    done_newlm   = 1'b0;
    result_0     = '0;
    result_1     = '0;
    result_2     = '0;
    result_3     = '0;
    ref_x        = '0;
    ref_y        = '0;
    ref_th       = '0;
    for (int s = 0; s < `LM_DEPTH; s++) begin
      ref_lx[s] = '0;
      ref_ly[s] = '0;
    end
    repeat (16) @(posedge clk);
    #1;
    sys_rst = 1'b0;
    @(negedge clk);

    // idle outputs straight out of reset
    err0 = err_cnt;
    assert (o_stage_rdy == 3'd0 && !o_init_predict && !o_init_newlm && !o_plb_en &&
            !o_plb_we) else begin
      err_cnt++;
      $display("** Error at %0t: control outputs active after reset", $time);
    end
    check_pose();
    finish_test("reset state", err0);

    err0 = err_cnt;
    run_stage(STAGE_PRD, '0);
    check_pose();
    finish_test("single predict", err0);

    err0 = err_cnt;
    run_stage(STAGE_NEW, `LM_IDX_W'($urandom % `LM_DEPTH));
    finish_test("single new landmark", err0);

    // mixed stages, then read back every slot
    err0 = err_cnt;
    for (int i = 0; i < MIX_STAGES; i++) begin
      if ($urandom % 2 == 1) begin
        run_stage(STAGE_NEW, `LM_IDX_W'($urandom % `LM_DEPTH));
      end else begin
        run_stage(STAGE_PRD, '0);
      end
    end
    for (int s = 0; s < `LM_DEPTH; s++) begin
      @(posedge clk);
      #1;
      l_k = `LM_IDX_W'(s);
      @(negedge clk);
      assert (o_lkx == ref_lx[s] && o_lky == ref_ly[s]) else begin
        err_cnt++;
        $display("** Error at %0t: slot %0d reads %0h %0h, expected %0h %0h",
                 $time, s, o_lkx, o_lky, ref_lx[s], ref_ly[s]);
      end
    end
    finish_test("mixed stages and readback", err0);

    // code 3 must be ignored
    err0 = err_cnt;
    prd0 = init_prd_cnt;
    new0 = init_new_cnt;
    rdy0 = rdy_cnt;
    wr0  = wr_cnt;
    @(posedge clk);
    #1;
    stage_val = 3'd3;
    repeat (20) @(negedge clk);
    @(posedge clk);
    #1;
    stage_val = STAGE_IDLE;
    @(negedge clk);
    assert (init_prd_cnt == prd0 && init_new_cnt == new0 && rdy_cnt == rdy0 &&
            wr_cnt == wr0) else begin
      err_cnt++;
      $display("** Error at %0t: unsupported stage code caused activity", $time);
    end
    finish_test("unsupported stage code", err0);

    err0 = err_cnt;
    for (int i = 0; i < PRD_RUNS; i++) begin
      run_stage(STAGE_PRD, '0);
      check_pose();
    end
    finish_test("predict accumulation", err0);

    $display("tests %0d, passed %0d, failed %0d, check errors %0d",
             pass_cnt + fail_cnt, pass_cnt, fail_cnt, err_cnt);
    if (fail_cnt == 0 && err_cnt == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sources.f */
+incdir+src
src/slam_pkg.sv
src/seq_if.sv
src/stage_ctrl.sv
src/pose_update.sv
src/landmark_store.sv
src/plb_writer.sv
src/slam_accel_top.sv
bench/slam_accel_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := slam_accel_tb
FILELIST  := sources.f
OBJ_DIR   := obj_dir
PASS_MSG  := === PASS ===

BIN  := $(OBJ_DIR)/V$(TOP)
SRCS := $(wildcard src/*.sv src/*.svh bench/*.sv)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) | tee /dev/stderr | grep -qF -e "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
